// File: obj_defines.svh
////////////////////////////////////////
// sprite renderer sizes
// table, queue and screen limits shared by the sprite blocks
////////////////////////////////////////

`ifndef OBJ_DEFINES_SVH
`define OBJ_DEFINES_SVH

// entries in the sprite attribute table
`define OBJ_NUM_SPRITES 64

// priority levels, level 0 is drawn first
`define OBJ_PRI_LEVELS 16

// queued sprites per level
`define OBJ_QUEUE_DEPTH 32

// visible pixels per line
`define OBJ_SCREEN_W 320

// 9-bit positions above this are negative
`define OBJ_WRAP_LIMIT 384

`endif

// File: obj_pkg.sv
////////////////////////////////////////
// sprite renderer types
// vector widths and FSM encodings
////////////////////////////////////////

`default_nettype none

package obj_pkg;

    typedef logic [5:0]         sprite_idx_t;   // attribute table index
    typedef logic [3:0]         pri_t;
    typedef logic [7:0]         ram_addr_t;     // four words per sprite
    typedef logic [15:0]        ram_word_t;
    typedef logic [5:0]         palette_t;
    typedef logic [14:0]        tile_num_t;
    typedef logic [15:0]        tile_offs_t;    // slice offset into the tile graphics
    typedef logic [31:0]        gfx_word_t;     // 8 pixels of 4 bits
    typedef logic signed [9:0]  pos_t;          // position after wrap
    typedef logic [8:0]         line_t;
    typedef logic [14:0]        pixel_t;        // priority, palette, colour code

    // five cycles per table entry, then a wait for the renderer
    typedef enum logic [2:0] {
        SC_IDLE, SC_A0, SC_A3, SC_L3, SC_TEST, SC_PUSH, SC_DONE, SC_WAIT
    } scan_state_t;

    typedef enum logic [2:0] {
        RS_IDLE, RS_LEVEL, RS_IDX, RS_IDXW, RS_ATTR, RS_TILE, RS_FETCH, RS_DRAW
    } render_state_t;

endpackage

`default_nettype wire

// File: obj_queue_if.sv
////////////////////////////////////////
// sprite queue interface
// scanner pushes, renderer reads back per level
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "obj_defines.svh"

interface obj_queue_if import obj_pkg::*; ();

    logic                       clear;          // pulse at line start
    logic                       push;
    pri_t                       push_pri;
    sprite_idx_t                push_idx;
    logic [5:0]                 level_count;    // 0 to 32 for rd_pri
    logic [`OBJ_PRI_LEVELS-1:0] pri_mask;       // non-empty levels
    pri_t                       rd_pri;
    logic [4:0]                 rd_pos;
    sprite_idx_t                rd_idx;         // one cycle after rd_pos

    modport scanner (output clear, push, push_pri, push_idx);
    modport queue (input clear, push, push_pri, push_idx, rd_pri, rd_pos,
                   output level_count, pri_mask, rd_idx);
    modport renderer (input level_count, pri_mask, rd_idx, output rd_pri, rd_pos);

endinterface

`default_nettype wire

// File: obj_line_scanner.sv
////////////////////////////////////////
// sprite line scanner
// walks the attribute table and queues
// every sprite that covers the render line
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "obj_defines.svh"

module obj_line_scanner import obj_pkg::*; (
    input  logic            CLK96,
    input  logic            RESET96,
    input  logic            line_start_i,
    input  line_t           vrender_i,
    input  ram_addr_t       rnd_addr_i,     // renderer address once scan is over
    output ram_addr_t       ram_addr_o,
    input  ram_word_t       ram_data_i,
    output logic            busy_o,
    output logic            scan_done_o,
    input  logic            render_done_i,
    obj_queue_if.scanner    q
);

    localparam sprite_idx_t LAST_IDX = sprite_idx_t'(`OBJ_NUM_SPRITES - 1);

    scan_state_t        state_q;
    sprite_idx_t        idx_q;
    line_t              v_q;
    logic               hit_q;
    logic               en_q;
    pri_t               pri_q;
    line_t              y_raw_q;
    logic [3:0]         ysize_q;
    pos_t               ypos;
    logic signed [10:0] dv;

    // wrap, then distance from the sprite top to the line
    assign ypos = (y_raw_q > `OBJ_WRAP_LIMIT) ? pos_t'({1'b1, y_raw_q}) : pos_t'({1'b0, y_raw_q});
    assign dv   = $signed({2'b00, v_q}) - 11'(ypos);

    always_comb begin
        case (state_q)
            SC_A0:   ram_addr_o = {idx_q, 2'd0};    // word 0, flags and priority
            SC_A3:   ram_addr_o = {idx_q, 2'd3};    // word 3, y and height
            default: ram_addr_o = rnd_addr_i;
        endcase
    end

    assign busy_o      = (state_q != SC_IDLE);
    assign scan_done_o = (state_q == SC_DONE);
    assign q.push      = (state_q == SC_PUSH) && hit_q;
    assign q.push_pri  = pri_q;
    assign q.push_idx  = idx_q;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state_q <= SC_IDLE;
            idx_q   <= '0;
            hit_q   <= 1'b0;
            v_q     <= '0;
            q.clear <= 1'b0;
        end else begin
            q.clear <= 1'b0;
            case (state_q)
                SC_IDLE: begin
                    if (line_start_i) begin
                        q.clear <= 1'b1;
                        v_q     <= vrender_i;
                        idx_q   <= '0;
                        state_q <= SC_A0;
                    end
                end
                SC_A0:   state_q <= SC_A3;
                SC_A3:   state_q <= SC_L3;
                SC_L3:   state_q <= SC_TEST;
                SC_TEST: begin
                    // covers when 0 <= dv < 8*(ysize+1)
                    hit_q   <= en_q && !dv[10] && (dv[9:3] <= 7'(ysize_q));
                    state_q <= SC_PUSH;
                end
                SC_PUSH: begin
                    idx_q   <= idx_q + 1'b1;
                    state_q <= (idx_q == LAST_IDX) ? SC_DONE : SC_A0;
                end
                SC_DONE: state_q <= SC_WAIT;
                SC_WAIT: begin
                    if (render_done_i) state_q <= SC_IDLE;
                end
                default: state_q <= SC_IDLE;
            endcase
        end
    end

    // attribute words arrive one cycle after their address
    always_ff @(posedge CLK96) begin
        if (state_q == SC_A3) begin
            en_q  <= ram_data_i[15];
            pri_q <= ram_data_i[11:8];
        end
        if (state_q == SC_L3) begin
            y_raw_q <= ram_data_i[15:7];
            ysize_q <= ram_data_i[3:0];
        end
    end

    // a new line may only start once the previous one is fully drawn
    a_start_idle: assert property (@(posedge CLK96) disable iff (RESET96)
        line_start_i |-> !busy_o)
        else $error("line start while busy");

endmodule

`default_nettype wire

// File: obj_priority_queue.sv
////////////////////////////////////////
// sprite priority queue
// index RAM with one fill counter per level
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "obj_defines.svh"

module obj_priority_queue import obj_pkg::*; (
    input  logic        CLK96,
    input  logic        RESET96,
    obj_queue_if.queue  q
);

    localparam int QW = $clog2(`OBJ_QUEUE_DEPTH);

    sprite_idx_t                idx_ram [`OBJ_PRI_LEVELS*`OBJ_QUEUE_DEPTH];
    logic [QW-1:0]              cnt_q [`OBJ_PRI_LEVELS];
    logic [`OBJ_PRI_LEVELS-1:0] mask_q;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            mask_q <= '0;
            for (int i = 0; i < `OBJ_PRI_LEVELS; i++) begin
                cnt_q[i] <= '0;
            end
        end else if (q.clear) begin
            mask_q <= '0;
            for (int i = 0; i < `OBJ_PRI_LEVELS; i++) begin
                cnt_q[i] <= '0;
            end
        end else if (q.push) begin
            cnt_q[q.push_pri]  <= cnt_q[q.push_pri] + 1'b1;  // wraps to 0 at 32 entries
            mask_q[q.push_pri] <= 1'b1;
        end
    end

    // RAM addressed by {level, position}
    always_ff @(posedge CLK96) begin
        if (q.push) begin
            idx_ram[{q.push_pri, cnt_q[q.push_pri]}] <= q.push_idx;
        end
        q.rd_idx <= idx_ram[{q.rd_pri, q.rd_pos}];
    end

    // a full level shows a zero count with its mask bit set
    assign q.level_count = {mask_q[q.rd_pri] && (cnt_q[q.rd_pri] == '0), cnt_q[q.rd_pri]};
    assign q.pri_mask    = mask_q;

    a_no_overflow: assert property (@(posedge CLK96) disable iff (RESET96)
        q.push |-> !(mask_q[q.push_pri] && (cnt_q[q.push_pri] == '0)))
        else $error("push to a full priority level");

endmodule

`default_nettype wire

// File: obj_tile_renderer.sv
////////////////////////////////////////
// sprite tile renderer
// drains the queues by priority, fetches slices
// and writes visible pixels to the line buffer
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "obj_defines.svh"

module obj_tile_renderer import obj_pkg::*; (
    input  logic            CLK96,
    input  logic            RESET96,
    input  logic            scan_done_i,
    input  line_t           vrender_i,
    obj_queue_if.renderer   q,
    output ram_addr_t       ram_addr_o,
    input  ram_word_t       ram_data_i,
    output logic            gfx_cs_o,
    input  logic            gfx_ok_i,
    output tile_num_t       tile_num_o,
    output tile_offs_t      tile_offs_o,
    input  gfx_word_t       gfx_data_i,
    output logic            buf_we_o,
    output line_t           buf_addr_o,
    output pixel_t          buf_data_o,
    output logic            render_done_o
);

    render_state_t              state_q;
    logic [`OBJ_PRI_LEVELS-1:0] mask_q;     // levels still to draw
    pri_t                       pri_q;
    pri_t                       next_pri;
    logic [5:0]                 pos_q;
    logic [2:0]                 ac_q;       // attribute word counter
    logic [4:0]                 col_q;
    logic [2:0]                 tx_q;

    line_t          v_q;
    sprite_idx_t    idx_q;
    logic           xflip_q;
    palette_t       pal_q;
    tile_num_t      tile_q;
    pos_t           xpos_q;
    pos_t           ypos_q;
    logic [3:0]     xsize_q;
    gfx_word_t      slice_q;

    logic signed [10:0] dy;
    logic signed [10:0] pix_x;
    logic [2:0]         px_k;
    logic [3:0]         code;
    logic               visible;
    tile_offs_t         row_base;
    tile_offs_t         cur_offs;

    function automatic pri_t lowest_bit(input logic [`OBJ_PRI_LEVELS-1:0] m);
        pri_t p;
        p = '0;
        for (int i = `OBJ_PRI_LEVELS - 1; i >= 0; i--) begin
            if (m[i]) p = pri_t'(i);
        end
        return p;
    endfunction

    assign next_pri = lowest_bit(mask_q);

    // slice offset for the current tile column
    assign dy       = $signed({2'b00, v_q}) - 11'(ypos_q);
    assign row_base = tile_offs_t'(dy[6:3]) * tile_offs_t'(xsize_q + 5'd1);
    assign cur_offs = (row_base << 5) + tile_offs_t'({dy[2:0], 2'b00})
                    + tile_offs_t'({col_q[3:0], 5'b00000});

    // nibble tx lands at column x + tx, mirrored inside the tile on flip
    assign px_k    = xflip_q ? (3'd7 - tx_q) : tx_q;
    assign pix_x   = 11'(xpos_q) + $signed({3'b000, col_q, 3'b000}) + $signed({8'h00, px_k});
    assign code    = slice_q[{tx_q, 2'b00} +: 4];
    assign visible = (code != 4'h0) && !pix_x[10] && (pix_x < `OBJ_SCREEN_W);

    assign q.rd_pri       = pri_q;
    assign q.rd_pos       = pos_q[4:0];
    assign ram_addr_o     = {idx_q, ac_q[1:0]};
    assign render_done_o  = (state_q == RS_LEVEL) && (mask_q == '0);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state_q  <= RS_IDLE;
            mask_q   <= '0;
            pri_q    <= '0;
            pos_q    <= '0;
            ac_q     <= '0;
            col_q    <= '0;
            tx_q     <= '0;
            gfx_cs_o <= 1'b0;
            buf_we_o <= 1'b0;
        end else begin
            buf_we_o <= 1'b0;
            case (state_q)
                RS_IDLE: begin
                    if (scan_done_i) begin
                        mask_q  <= q.pri_mask;
                        state_q <= RS_LEVEL;
                    end
                end
                RS_LEVEL: begin
                    if (mask_q == '0) begin
                        state_q <= RS_IDLE;
                    end else begin
                        pri_q            <= next_pri;
                        mask_q[next_pri] <= 1'b0;
                        pos_q            <= '0;
                        state_q          <= RS_IDX;
                    end
                end
                RS_IDX: state_q <= (pos_q == q.level_count) ? RS_LEVEL : RS_IDXW;
                RS_IDXW: begin
                    ac_q    <= '0;
                    state_q <= RS_ATTR;
                end
                RS_ATTR: begin
                    ac_q <= ac_q + 1'b1;
                    if (ac_q == 3'd4) begin
                        col_q   <= '0;
                        state_q <= RS_TILE;
                    end
                end
                RS_TILE: begin
                    if (col_q > {1'b0, xsize_q}) begin  // sprite finished
                        pos_q   <= pos_q + 1'b1;
                        state_q <= RS_IDX;
                    end else begin
                        gfx_cs_o <= 1'b1;
                        state_q  <= RS_FETCH;
                    end
                end
                RS_FETCH: begin
                    if (gfx_ok_i) begin
                        gfx_cs_o <= 1'b0;
                        tx_q     <= '0;
                        state_q  <= RS_DRAW;
                    end
                end
                RS_DRAW: begin
                    buf_we_o <= visible;
                    tx_q     <= tx_q + 1'b1;
                    if (tx_q == 3'd7) begin
                        col_q   <= col_q + 1'b1;
                        state_q <= RS_TILE;
                    end
                end
                default: state_q <= RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (state_q == RS_IDLE && scan_done_i) v_q <= vrender_i;
        if (state_q == RS_IDXW) idx_q <= q.rd_idx;
        if (state_q == RS_ATTR) begin
            case (ac_q)     // data for word ac_q-1
                3'd1: begin
                    xflip_q <= ram_data_i[12];
                    pal_q   <= ram_data_i[5:0];
                end
                3'd2: tile_q <= ram_data_i[14:0];
                3'd3: begin
                    xpos_q  <= (ram_data_i[15:7] > `OBJ_WRAP_LIMIT) ?
                               pos_t'({1'b1, ram_data_i[15:7]}) : pos_t'({1'b0, ram_data_i[15:7]});
                    xsize_q <= ram_data_i[3:0];
                end
                3'd4: ypos_q <= (ram_data_i[15:7] > `OBJ_WRAP_LIMIT) ?
                                pos_t'({1'b1, ram_data_i[15:7]}) : pos_t'({1'b0, ram_data_i[15:7]});
                default: ;
            endcase
        end
        if (state_q == RS_TILE) begin
            tile_num_o  <= tile_q;
            tile_offs_o <= cur_offs;
        end
        if (state_q == RS_FETCH && gfx_ok_i) slice_q <= gfx_data_i;
        if (state_q == RS_DRAW) begin
            buf_addr_o <= line_t'(pix_x[8:0]);
            buf_data_o <= pixel_t'({pri_q, 2'b00, pal_q, code});  // pri*4096 + pal*16 + code
        end
    end

    // the graphics request is held until the memory accepts it
    a_gfx_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        gfx_cs_o && !gfx_ok_i |=> gfx_cs_o)
        else $error("gfx_cs_o dropped before gfx_ok_i");

endmodule

`default_nettype wire

// File: obj_line_buffer.sv
////////////////////////////////////////
// sprite line buffer
// one half is drawn while the other is read out
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module obj_line_buffer import obj_pkg::*; (
    input  logic    CLK96,
    input  logic    RESET96,
    input  logic    line_start_i,
    input  logic    we_i,
    input  line_t   wr_addr_i,
    input  pixel_t  wr_data_i,
    input  logic    pixel_cen_i,
    input  line_t   h_i,
    output pixel_t  pixel_o
);

    pixel_t             mem [1024];     // {half, x}
    logic [1:0][511:0]  valid_q;        // entry written since last readout
    logic               wr_half_q;
    pixel_t             rd_q;

    always_ff @(posedge CLK96) begin
        if (we_i) mem[{wr_half_q, wr_addr_i}] <= wr_data_i;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            wr_half_q <= 1'b0;
            valid_q   <= '0;
            rd_q      <= '0;
            pixel_o   <= '0;
        end else begin
            if (line_start_i) wr_half_q <= ~wr_half_q;
            if (we_i) valid_q[wr_half_q][wr_addr_i] <= 1'b1;
            if (pixel_cen_i) begin
                // read and clear, so the half starts empty on its next line
                rd_q <= valid_q[~wr_half_q][h_i] ? mem[{~wr_half_q, h_i}] : '0;
                valid_q[~wr_half_q][h_i] <= 1'b0;
            end
            pixel_o <= rd_q;    // only changes after a pixel_cen_i read
        end
    end

endmodule

`default_nettype wire

// File: obj_top.sv
////////////////////////////////////////
// sprite line renderer top
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module obj_top import obj_pkg::*; (
    input  logic        CLK96,
    input  logic        RESET96,
    input  logic        line_start_i,
    input  line_t       vrender_i,
    output ram_addr_t   ram_addr_o,
    input  ram_word_t   ram_data_i,
    output logic        gfx_cs_o,
    input  logic        gfx_ok_i,
    output tile_num_t   tile_num_o,
    output tile_offs_t  tile_offs_o,
    input  gfx_word_t   gfx_data_i,
    input  logic        pixel_cen_i,
    input  line_t       h_i,
    output pixel_t      pixel_o,
    output logic        busy_o
);

    logic       scan_done;
    logic       render_done;
    ram_addr_t  rnd_addr;       // routed through the scanner
    logic       buf_we;
    line_t      buf_addr;
    pixel_t     buf_data;

    obj_queue_if qif ();

    obj_line_scanner u_scan (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .line_start_i   (line_start_i),
        .vrender_i      (vrender_i),
        .rnd_addr_i     (rnd_addr),
        .ram_addr_o     (ram_addr_o),
        .ram_data_i     (ram_data_i),
        .busy_o         (busy_o),
        .scan_done_o    (scan_done),
        .render_done_i  (render_done),
        .q              (qif.scanner)
    );

    obj_priority_queue u_queue (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .q          (qif.queue)
    );

    obj_tile_renderer u_rend (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .scan_done_i    (scan_done),
        .vrender_i      (vrender_i),
        .q              (qif.renderer),
        .ram_addr_o     (rnd_addr),
        .ram_data_i     (ram_data_i),
        .gfx_cs_o       (gfx_cs_o),
        .gfx_ok_i       (gfx_ok_i),
        .tile_num_o     (tile_num_o),
        .tile_offs_o    (tile_offs_o),
        .gfx_data_i     (gfx_data_i),
        .buf_we_o       (buf_we),
        .buf_addr_o     (buf_addr),
        .buf_data_o     (buf_data),
        .render_done_o  (render_done)
    );

    obj_line_buffer u_lbuf (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .line_start_i   (line_start_i),
        .we_i           (buf_we),
        .wr_addr_i      (buf_addr),
        .wr_data_i      (buf_data),
        .pixel_cen_i    (pixel_cen_i),
        .h_i            (h_i),
        .pixel_o        (pixel_o)
    );

endmodule

`default_nettype wire

// File: tb_obj_top.sv
////////////////////////////////////////
// sprite renderer testbench
// sprite RAM and graphics ROM models,
// reference pixels and line readout checks
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "obj_defines.svh"

module tb_obj_top import obj_pkg::*; ();

    localparam int LINES = 18;  // lines rendered over all tests
    localparam int LIMIT = LINES * (5*64 + 64*16*(8+12) + 1400);

    logic       CLK96;
    logic       RESET96;
    logic       line_start_i;
    line_t      vrender_i;
    ram_addr_t  ram_addr_o;
    ram_word_t  ram_data_i;
    logic       gfx_cs_o;
    logic       gfx_ok_i;
    tile_num_t  tile_num_o;
    tile_offs_t tile_offs_o;
    gfx_word_t  gfx_data_i;
    logic       pixel_cen_i;
    line_t      h_i;
    pixel_t     pixel_o;
    logic       busy_o;

    ram_word_t  sprite_ram [256];
    ram_addr_t  ram_rd_addr;
    pixel_t     exp_line [`OBJ_SCREEN_W];
    integer     seed;
    int         cycles;
    int         lat_cnt;
    int         lat_goal;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;
    int         test_mark;
    logic       cen_d1;
    logic       cen_d2;
    line_t      h_d1;
    line_t      h_d2;

    obj_top DUT (.*);

    always #2 CLK96 = ~CLK96;

    always @(posedge CLK96) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("run stopped after %0d cycles, the DUT did not finish a line", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // sprite RAM, one cycle read latency
    always @(posedge CLK96) ram_rd_addr <= ram_addr_o;
    always @(negedge CLK96) ram_data_i <= sprite_ram[ram_rd_addr];

    function automatic gfx_word_t gfx_slice(input tile_num_t t, input tile_offs_t o);
        gfx_word_t w;
        w = {t[13:0], 2'b01, o} * 32'h9e3779b1;
        w = w ^ (w >> 13);
        if (t[14]) w = w & 32'h0f0f0f0f;    // sparse tile, every other pixel clear
        return w;
    endfunction

    // graphics ROM, acknowledges after 1 to 6 cycles
    always @(negedge CLK96) begin
        if (!gfx_cs_o) begin
            gfx_ok_i = 1'b0;
            lat_cnt  = 0;
        end else if (!gfx_ok_i) begin
            if (lat_cnt == 0) lat_goal = 1 + int'($unsigned($random(seed)) % 6);
            lat_cnt = lat_cnt + 1;
            if (lat_cnt >= lat_goal) begin
                gfx_data_i = gfx_slice(tile_num_o, tile_offs_o);
                gfx_ok_i   = 1'b1;
            end
        end
    end

    // draw order is priority then index, so the last opaque hit wins
    function automatic pixel_t ref_pixel(input line_t v, input int h);
        pixel_t     best;
        int         best_pri;
        ram_word_t  w0;
        ram_word_t  w1;
        ram_word_t  w2;
        ram_word_t  w3;
        int         x;
        int         y;
        int         dx;
        int         dy;
        logic [2:0] k;
        tile_offs_t offs;
        gfx_word_t  slice;
        logic [3:0] code;
        best     = '0;
        best_pri = -1;
        for (int i = 0; i < `OBJ_NUM_SPRITES; i++) begin
            w0 = sprite_ram[ram_addr_t'(4*i)];
            w1 = sprite_ram[ram_addr_t'(4*i + 1)];
            w2 = sprite_ram[ram_addr_t'(4*i + 2)];
            w3 = sprite_ram[ram_addr_t'(4*i + 3)];
            x  = int'(w2[15:7]);
            y  = int'(w3[15:7]);
            if (x > `OBJ_WRAP_LIMIT) x = x - 512;
            if (y > `OBJ_WRAP_LIMIT) y = y - 512;
            dx = h - x;
            dy = int'(v) - y;
            if (w0[15] && dy >= 0 && dy < 8*(int'(w3[3:0]) + 1)
                    && dx >= 0 && dx < 8*(int'(w2[3:0]) + 1)) begin
                offs  = tile_offs_t'((dy/8)*(int'(w2[3:0]) + 1)*32 + (dy%8)*4 + (dx/8)*32);
                k     = w0[12] ? 3'(7 - dx%8) : 3'(dx%8);
                slice = gfx_slice(w1[14:0], offs);
                code  = slice[{k, 2'b00} +: 4];
                if (code != 4'h0 && int'(w0[11:8]) >= best_pri) begin
                    best_pri = int'(w0[11:8]);
                    best     = pixel_t'(best_pri*4096 + int'(w0[5:0])*16 + int'(code));
                end
            end
        end
        return best;
    endfunction

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // pixel_o holds the read issued two edges earlier
    always @(posedge CLK96) begin
        cen_d1 <= pixel_cen_i;
        cen_d2 <= cen_d1;
        h_d1   <= h_i;
        h_d2   <= h_d1;
    end

    always @(negedge CLK96) begin
        if (cen_d2) check_pixel($sformatf("pixel_o h=%0d", h_d2), pixel_o, exp_line[h_d2]);
    end

    task automatic set_sprite(input int idx, input logic en, input logic flip, input pri_t pri,
                              input palette_t pal, input tile_num_t tile,
                              input int x, input int y, input int xs, input int ys);
        ram_addr_t a;
        a = ram_addr_t'(idx * 4);
        sprite_ram[a]         = {en, 2'b00, flip, pri, 2'b00, pal};
        sprite_ram[a + 8'd1]  = {1'b0, tile};
        sprite_ram[a + 8'd2]  = {9'(x), 3'b000, 4'(xs)};
        sprite_ram[a + 8'd3]  = {9'(y), 3'b000, 4'(ys)};
    endtask

    task automatic clear_table();
        for (int a = 0; a < 256; a++) begin
            sprite_ram[ram_addr_t'(a)] = '0;
        end
    endtask

    task automatic start_line();
        line_start_i = 1'b1;
        @(negedge CLK96);
        line_start_i = 1'b0;
        check_flag("busy_o", busy_o, 1'b1);
        while (busy_o) @(negedge CLK96);
        check_flag("gfx_cs_o", gfx_cs_o, 1'b0);
    endtask

    // render, swap halves (the line renders again into the other half), read back
    task automatic run_line(input line_t v);
        for (int h = 0; h < `OBJ_SCREEN_W; h++) begin
            exp_line[line_t'(h)] = ref_pixel(v, h);
        end
        vrender_i = v;
        start_line();
        start_line();
        for (int h = 0; h < `OBJ_SCREEN_W; h++) begin
            pixel_cen_i = 1'b1;
            h_i         = line_t'(h);
            @(negedge CLK96);
            pixel_cen_i = 1'b0;
            repeat (3) @(negedge CLK96);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_mark) begin
            $display("test %-8s passed", name);
        end else begin
            tests_failed++;
            $display("test %-8s failed with %0d mismatches", name, errors - test_mark);
        end
        test_mark = errors;
    endtask

    initial begin
        logic [31:0] r;
        line_t       v;
        CLK96        = 1'b0;
        RESET96      = 1'b1;
        line_start_i = 1'b0;
        vrender_i    = '0;
        ram_data_i   = '0;
        gfx_ok_i     = 1'b0;
        gfx_data_i   = '0;
        pixel_cen_i  = 1'b0;
        h_i          = '0;
        cen_d1       = 1'b0;
        cen_d2       = 1'b0;
        seed         = 32'h413a0ef8;
        cycles       = 0;
        lat_cnt      = 0;
        lat_goal     = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_mark    = 0;
        clear_table();
        repeat (16) @(posedge CLK96);
        @(negedge CLK96);
        RESET96 = 1'b0;

        check_flag("busy_o", busy_o, 1'b0);
        check_flag("gfx_cs_o", gfx_cs_o, 1'b0);
        check_pixel("pixel_o", pixel_o, '0);
        run_line(9'd50);        // empty table
        end_test("reset");

        set_sprite(0, 1'b1, 1'b0, 4'd3, 6'd10, 15'h0123, 20, 40, 0, 0);
        set_sprite(5, 1'b1, 1'b0, 4'd6, 6'd33, 15'h0456, 60, 30, 2, 1);
        set_sprite(9, 1'b1, 1'b0, 4'd1, 6'd63, 15'h1abc, 120, 8, 15, 5);
        set_sprite(12, 1'b0, 1'b0, 4'd9, 6'd5, 15'h0777, 130, 40, 3, 3);  // disabled
        run_line(9'd42);
        run_line(9'd47);
        run_line(9'd50);
        end_test("single");

        clear_table();
        set_sprite(2, 1'b1, 1'b1, 4'd4, 6'd7, 15'h0222, 40, 100, 3, 0);
        set_sprite(3, 1'b1, 1'b0, 4'd4, 6'd7, 15'h0222, 140, 100, 3, 0);
        run_line(9'd103);
        end_test("flip");

        clear_table();
        set_sprite(1, 1'b1, 1'b0, 4'd9, 6'd1, 15'h4010, 100, 60, 3, 1);   // sparse, on top
        set_sprite(6, 1'b1, 1'b0, 4'd2, 6'd2, 15'h0020, 110, 60, 3, 1);
        set_sprite(20, 1'b1, 1'b0, 4'd7, 6'd3, 15'h0030, 200, 60, 2, 1);
        set_sprite(21, 1'b1, 1'b0, 4'd7, 6'd4, 15'h4040, 208, 60, 2, 1);
        run_line(9'd70);
        end_test("overlap");

        clear_table();
        set_sprite(0, 1'b1, 1'b0, 4'd5, 6'd9, 15'h0300, 500, 20, 2, 0);   // x -12
        set_sprite(1, 1'b1, 1'b1, 4'd5, 6'd9, 15'h0301, 310, 20, 1, 0);
        set_sprite(2, 1'b1, 1'b0, 4'd8, 6'd12, 15'h0302, 150, 508, 1, 1); // y -4
        set_sprite(3, 1'b1, 1'b0, 4'd8, 6'd12, 15'h0303, 385, 20, 15, 0); // only x 0 visible
        run_line(9'd22);
        run_line(9'd5);
        end_test("edges");

        for (int n = 0; n < 10; n++) begin
            v = line_t'($unsigned($random(seed)) % 240);
            for (int i = 0; i < `OBJ_NUM_SPRITES; i++) begin
                r = $random(seed);
                set_sprite(i, r[0], r[1], pri_t'(r[7:4]), palette_t'(r[13:8]),
                           tile_num_t'($random(seed)), int'($unsigned($random(seed)) % 512),
                           int'(v) - int'(r[19:14]), int'(r[23:20]), int'(r[27:24]));
            end
            run_line(v);
        end
        end_test("random");

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
obj_pkg.sv
obj_queue_if.sv
obj_line_scanner.sv
obj_priority_queue.sv
obj_tile_renderer.sv
obj_line_buffer.sv
obj_top.sv
tb_obj_top.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, then look for the fail message in the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_obj_top -f list.f \
    && { ./obj_dir/Vtb_obj_top > sim.log 2>&1 || true; } \
    && cat sim.log \
    && grep -q "No errors" sim.log \
    && ! grep -q "Errors found" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
